// File: src/etx_pkg.sv
// Shared constants and types for the eMesh transmit link
// Packet format is fixed at 104 bits, sent as 13 bytes with the MSB first
// Control-mode field sits in bits 6..3 and bit 7 is cleared by the splice

package etx_pkg;

   // ##########################################################
   // Packet and frame geometry
   // ##########################################################

   // Full eMesh packet width
   localparam int pw = 104;

   // Bytes per frame on the 8-bit pin bus
   localparam int nbytes = 13;

   // Enough to hold nbytes-1
   localparam int cnt_w = 4;

   // ##########################################################
   // Control-mode field inside the packet
   // ##########################################################

   // Low and high bits of the control-mode field
   localparam int ctrl_lsb = 3;
   localparam int ctrl_msb = 6;

   // ##########################################################
   // Serializer states
   // ##########################################################

   // Idle waits for a registered packet, shift sends its bytes
   typedef enum logic
   {
      link_idle  = 1'b0,
      link_shift = 1'b1
   } link_state_t;

endpackage

// File: src/etx_arbiter.sv
// Fixed-priority arbiter for the write, read-request and read-response channels
// Priority is write, then read response, then read request
// Remote waits freeze the output register and hide a pending access from the link
// The packet register has no reset and loads only on a transfer

`timescale 1ns/1ps

module etx_arbiter
(
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   txwr_access,
   input  logic                   txrd_access,
   input  logic                   txrr_access,
   input  logic [etx_pkg::pw-1:0] txwr_packet,
   input  logic [etx_pkg::pw-1:0] txrd_packet,
   input  logic [etx_pkg::pw-1:0] txrr_packet,
   output logic                   txwr_wait,
   output logic                   txrd_wait,
   output logic                   txrr_wait,
   input  logic                   tx_wr_wait,
   input  logic                   tx_rd_wait,
   input  logic                   link_busy,
   input  logic                   ctrlmode_bypass,
   input  logic [3:0]             ctrlmode,
   output logic                   etx_access,
   output logic                   etx_rr,
   output logic [etx_pkg::pw-1:0] etx_packet
);

   logic [etx_pkg::pw-1:0] wr_splice;
   logic [etx_pkg::pw-1:0] rd_splice;
   logic [etx_pkg::pw-1:0] pkt_mux;
   logic                   stall;
   logic                   remote_stall;
   logic                   wr_grant;
   logic                   rd_grant;
   logic                   rr_grant;
   logic                   access_in;
   logic                   access_q;

   // ##########################################################
   // Control-mode splice
   // ##########################################################

   always_comb
   begin
      wr_splice = txwr_packet;
      rd_splice = txrd_packet;
      // Bit above the field always cleared
      wr_splice[etx_pkg::ctrl_msb+1] = 1'b0;
      rd_splice[etx_pkg::ctrl_msb+1] = 1'b0;
      // Bypass overrides the field from the pin value
      if (ctrlmode_bypass)
      begin
         wr_splice[etx_pkg::ctrl_msb:etx_pkg::ctrl_lsb] = ctrlmode;
         rd_splice[etx_pkg::ctrl_msb:etx_pkg::ctrl_lsb] = ctrlmode;
      end
   end

   // ##########################################################
   // Wait levels
   // ##########################################################

   assign remote_stall = tx_wr_wait | tx_rd_wait;
   assign stall        = remote_stall | link_busy;

   // Responses yield to writes, reads yield to both
   assign txwr_wait = stall;
   assign txrr_wait = stall | txwr_access;
   assign txrd_wait = stall | txwr_access | txrr_access;

   // ##########################################################
   // Fixed-priority grant on channels able to transfer
   // ##########################################################

   // Priority comes from the wait levels alone
   assign wr_grant  = txwr_access & ~txwr_wait;
   assign rd_grant  = txrd_access & ~txrd_wait;
   assign rr_grant  = txrr_access & ~txrr_wait;
   assign access_in = wr_grant | rd_grant | rr_grant;

   // Winner's packet, response passes unspliced
   assign pkt_mux = ({etx_pkg::pw{wr_grant}} & wr_splice) |
                    ({etx_pkg::pw{rd_grant}} & rd_splice) |
                    ({etx_pkg::pw{rr_grant}} & txrr_packet);

   // ##########################################################
   // Output pipeline register
   // ##########################################################

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         access_q <= 1'b0;
         etx_rr   <= 1'b0;
      end
      else if (!remote_stall)
      begin
         access_q <= access_in;
         etx_rr   <= rr_grant;
      end
   end

   always_ff @(posedge clk)
   begin
      if (access_in)
         etx_packet <= pkt_mux;
   end

   // Pending access is held back from the link during a remote stall
   assign etx_access = access_q & ~remote_stall;

   // Wait levels leave at most one channel granted
   a_grant_onehot : assert property (@(posedge clk) disable iff (!nreset)
      $onehot0({wr_grant, rd_grant, rr_grant}));

endmodule

// File: src/etx_link_fsm.sv
// Frame control for the byte serializer
// Accepts a registered packet only while idle, sends one frame of nbytes cycles
// Frames are never paused, remote waits act on the arbiter only

`timescale 1ns/1ps

module etx_link_fsm
(
   input  logic clk,
   input  logic nreset,
   input  logic etx_access,
   input  logic cnt_last,
   output logic link_busy,
   output logic load,
   output logic shift_en,
   output logic tx_frame
);

   etx_pkg::link_state_t state;
   etx_pkg::link_state_t state_nxt;

   // ##########################################################
   // Next state
   // ##########################################################

   always_comb
   begin
      state_nxt = state;
      case (state)
         etx_pkg::link_idle:
         begin
            // Packet waiting in the arbiter register
            if (etx_access)
               state_nxt = etx_pkg::link_shift;
         end
         etx_pkg::link_shift:
         begin
            // Byte 0 on the pins this cycle
            if (cnt_last)
               state_nxt = etx_pkg::link_idle;
         end
         default:
            state_nxt = etx_pkg::link_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!nreset)
         state <= etx_pkg::link_idle;
      else
         state <= state_nxt;
   end

   // ##########################################################
   // Outputs
   // ##########################################################

   // Capture into the shift register on acceptance
   assign load = (state == etx_pkg::link_idle) & etx_access;

   // No shift on the last byte, the counter stops at zero
   assign shift_en = (state == etx_pkg::link_shift) & ~cnt_last;

   assign tx_frame = (state == etx_pkg::link_shift);

   // Blocks the arbiter from accepting while a packet is pending or in flight
   assign link_busy = etx_access | (state == etx_pkg::link_shift);

   // Arbiter must not present a packet while a frame is going out
   a_no_access_in_shift : assert property (@(posedge clk) disable iff (!nreset)
      (state == etx_pkg::link_shift) |-> !etx_access);

endmodule

// File: src/etx_byte_counter.sv
// Counts bytes left in the current frame
// Loads nbytes-1 and counts down to zero, cnt_last flags the final byte

`timescale 1ns/1ps

module etx_byte_counter
(
   input  logic clk,
   input  logic nreset,
   input  logic load,
   input  logic shift_en,
   output logic cnt_last
);

   logic [etx_pkg::cnt_w-1:0] cnt;

   // Down-counter, load wins over decrement
   always_ff @(posedge clk)
   begin
      if (!nreset)
         cnt <= '0;
      else if (load)
         cnt <= etx_pkg::cnt_w'(etx_pkg::nbytes - 1);
      else if (shift_en)
         cnt <= cnt - 1'b1;
   end

   // Zero means byte 0 is on the pins
   assign cnt_last = (cnt == '0);

   // FSM must stop shifting before the count wraps
   a_no_underflow : assert property (@(posedge clk) disable iff (!nreset)
      shift_en |-> !cnt_last);

endmodule

// File: src/etx_shift_reg.sv
// Packet shift register for the 8-bit pin bus
// Most significant byte goes out first, one byte per shift
// Holds its contents between frames, no reset on the payload

`timescale 1ns/1ps

module etx_shift_reg
(
   input  logic                   clk,
   input  logic                   load,
   input  logic                   shift_en,
   input  logic [etx_pkg::pw-1:0] etx_packet,
   input  logic                   etx_rr,
   output logic [7:0]             tx_data,
   output logic                   tx_rr
);

   logic [etx_pkg::pw-1:0] pkt_q;
   logic                   rr_q;

   // ##########################################################
   // Capture and shift
   // ##########################################################

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         pkt_q <= etx_packet;
         rr_q  <= etx_rr;
      end
      else if (shift_en)
      begin
         // Next byte moves into the top position
         pkt_q <= {pkt_q[etx_pkg::pw-9:0], 8'h00};
      end
   end

   // Top byte drives the pins
   assign tx_data = pkt_q[etx_pkg::pw-1 -: 8];

   // Response flag stays put for the whole frame
   assign tx_rr = rr_q;

endmodule

// File: src/etx_top.sv
// Transmit side of an eMesh link, three packet channels into one 8-bit pin bus
// A packet goes out as 13 bytes under tx_frame, first byte 2 edges after acceptance
// tx_rr marks read responses and is only meaningful while tx_frame is high

`timescale 1ns/1ps

module etx_top
(
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   txwr_access,
   input  logic                   txrd_access,
   input  logic                   txrr_access,
   input  logic [etx_pkg::pw-1:0] txwr_packet,
   input  logic [etx_pkg::pw-1:0] txrd_packet,
   input  logic [etx_pkg::pw-1:0] txrr_packet,
   output logic                   txwr_wait,
   output logic                   txrd_wait,
   output logic                   txrr_wait,
   input  logic                   tx_wr_wait,
   input  logic                   tx_rd_wait,
   input  logic                   ctrlmode_bypass,
   input  logic [3:0]             ctrlmode,
   output logic                   tx_frame,
   output logic [7:0]             tx_data,
   output logic                   tx_rr
);

   // Arbiter to link
   logic                   etx_access;
   logic                   etx_rr;
   logic [etx_pkg::pw-1:0] etx_packet;
   logic                   link_busy;

   // Serializer internals
   logic load;
   logic shift_en;
   logic cnt_last;
   logic rr_flag;

   // ##########################################################
   // Channel arbitration
   // ##########################################################

   etx_arbiter u_arbiter
   (
      .clk             (clk),
      .nreset          (nreset),
      .txwr_access     (txwr_access),
      .txrd_access     (txrd_access),
      .txrr_access     (txrr_access),
      .txwr_packet     (txwr_packet),
      .txrd_packet     (txrd_packet),
      .txrr_packet     (txrr_packet),
      .txwr_wait       (txwr_wait),
      .txrd_wait       (txrd_wait),
      .txrr_wait       (txrr_wait),
      .tx_wr_wait      (tx_wr_wait),
      .tx_rd_wait      (tx_rd_wait),
      .link_busy       (link_busy),
      .ctrlmode_bypass (ctrlmode_bypass),
      .ctrlmode        (ctrlmode),
      .etx_access      (etx_access),
      .etx_rr          (etx_rr),
      .etx_packet      (etx_packet)
   );

   // ##########################################################
   // Byte serializer
   // ##########################################################

   etx_link_fsm u_link_fsm
   (
      .clk        (clk),
      .nreset     (nreset),
      .etx_access (etx_access),
      .cnt_last   (cnt_last),
      .link_busy  (link_busy),
      .load       (load),
      .shift_en   (shift_en),
      .tx_frame   (tx_frame)
   );

   etx_byte_counter u_byte_counter
   (
      .clk      (clk),
      .nreset   (nreset),
      .load     (load),
      .shift_en (shift_en),
      .cnt_last (cnt_last)
   );

   etx_shift_reg u_shift_reg
   (
      .clk        (clk),
      .load       (load),
      .shift_en   (shift_en),
      .etx_packet (etx_packet),
      .etx_rr     (etx_rr),
      .tx_data    (tx_data),
      .tx_rr      (rr_flag)
   );

   // Flag shown on the pin only inside a frame
   assign tx_rr = rr_flag & tx_frame;

endmodule

// File: verification/etx_tb.sv
// Testbench for the eMesh transmit link
// Channels are driven on the falling edge, frames are rebuilt at the rising edge
// Expected frames are queued in the arbitration order each test expects
// Run ends after a fixed cycle limit if the frame queue never drains

`timescale 1ns/1ps

module etx_tb;

   typedef logic [etx_pkg::pw-1:0] pkt_t;

   // Worst case about 40 frames of 16 cycles plus the wait tests, doubled
   localparam int max_cycles = 3000;

   // DUT ports
   logic       clk;
   logic       nreset;
   logic       txwr_access;
   logic       txrd_access;
   logic       txrr_access;
   pkt_t       txwr_packet;
   pkt_t       txrd_packet;
   pkt_t       txrr_packet;
   logic       txwr_wait;
   logic       txrd_wait;
   logic       txrr_wait;
   logic       tx_wr_wait;
   logic       tx_rd_wait;
   logic       ctrlmode_bypass;
   logic [3:0] ctrlmode;
   logic       tx_frame;
   logic [7:0] tx_data;
   logic       tx_rr;

   // Per-channel packets still to send, expected frames and flags
   pkt_t wr_q[$];
   pkt_t rd_q[$];
   pkt_t rr_q[$];
   pkt_t exp_q[$];
   logic exp_rr_q[$];

   int   cyc = 0;
   int   errors = 0;
   int   checks = 0;
   int   err_mark = 0;
   int   start_mark = 0;
   int   rr_sent = 0;
   int   rr_frames = 0;
   int   frames_started = 0;
   int   accept_cyc = 0;
   int   first_cyc = 0;
   int   nb = 0;
   logic wr_fire = 1'b0;
   logic rd_fire = 1'b0;
   logic rr_fire = 1'b0;
   logic rr_frame = 1'b0;
   pkt_t frame_buf;

   etx_top dut (.*);

   always #4 clk = ~clk;

   // ##########################################################
   // Reference model and helpers
   // ##########################################################

   // Kind 0 write, 1 read request, 2 response
   function automatic pkt_t expected_frame(input int kind, input pkt_t pkt,
                                           input logic byp, input logic [3:0] cm);
      pkt_t f;
      f = pkt;
      if (kind != 2)
      begin
         f[etx_pkg::ctrl_msb+1] = 1'b0;
         if (byp)
            f[etx_pkg::ctrl_msb:etx_pkg::ctrl_lsb] = cm;
      end
      return f;
   endfunction

   function automatic pkt_t rand_packet();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      // Bit above the control field set, so the splice always has to clear it
      r[etx_pkg::ctrl_msb+1] = 1'b1;
      return r[etx_pkg::pw-1:0];
   endfunction

   task automatic check_value(input string name, input pkt_t got, input pkt_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // All offered at once, so frames follow write, response, read priority
   task automatic offer_batch(input int nwr, input int nrd, input int nrr);
      pkt_t p;
      int   i;
      for (i = 0; i < nwr; i++)
      begin
         p = rand_packet();
         wr_q.push_back(p);
         exp_q.push_back(expected_frame(0, p, ctrlmode_bypass, ctrlmode));
         exp_rr_q.push_back(1'b0);
      end
      for (i = 0; i < nrr; i++)
      begin
         p = rand_packet();
         rr_q.push_back(p);
         exp_q.push_back(expected_frame(2, p, ctrlmode_bypass, ctrlmode));
         exp_rr_q.push_back(1'b1);
         rr_sent++;
      end
      for (i = 0; i < nrd; i++)
      begin
         p = rand_packet();
         rd_q.push_back(p);
         exp_q.push_back(expected_frame(1, p, ctrlmode_bypass, ctrlmode));
         exp_rr_q.push_back(1'b0);
      end
   endtask

   // One falling edge, retire taken packets, present the next ones
   task automatic step();
      @(negedge clk);
      if (!$onehot0({wr_fire, rd_fire, rr_fire}))
      begin
         errors++;
         $display("error: more than one channel transferred on the same edge");
      end
      if (wr_fire)
         void'(wr_q.pop_front());
      if (rd_fire)
         void'(rd_q.pop_front());
      if (rr_fire)
         void'(rr_q.pop_front());
      txwr_access = (wr_q.size() != 0);
      txrd_access = (rd_q.size() != 0);
      txrr_access = (rr_q.size() != 0);
      if (wr_q.size() != 0)
         txwr_packet = wr_q[0];
      if (rd_q.size() != 0)
         txrd_packet = rd_q[0];
      if (rr_q.size() != 0)
         txrr_packet = rr_q[0];
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
         step();
      // Idle tail catches a repeated frame
      repeat (20)
         step();
   endtask

   task automatic report_test(input string name);
      if (errors == err_mark)
         $display("test %s: ok", name);
      else
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   // ##########################################################
   // Transfer sampling, cycle count and timeout
   // ##########################################################

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      wr_fire <= txwr_access & ~txwr_wait;
      rd_fire <= txrd_access & ~txrd_wait;
      rr_fire <= txrr_access & ~txrr_wait;
      if ((txwr_access & ~txwr_wait) | (txrd_access & ~txrd_wait) |
          (txrr_access & ~txrr_wait))
         accept_cyc <= cyc;
      if (cyc == max_cycles)
      begin
         $display("timeout: frames still pending after %0d cycles", max_cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ##########################################################
   // Frame monitor
   // ##########################################################

   always @(posedge clk)
   begin
      if (!nreset)
         nb = 0;
      else if (tx_frame)
      begin
         if (nb == 0)
         begin
            first_cyc = cyc;
            frames_started++;
            rr_frame = tx_rr;
         end
         else if (tx_rr !== rr_frame)
         begin
            errors++;
            $display("error: tx_rr changed in the middle of a frame");
         end
         // Most significant byte arrives first
         frame_buf = {frame_buf[etx_pkg::pw-9:0], tx_data};
         nb++;
      end
      else
      begin
         if (tx_rr !== 1'b0)
         begin
            errors++;
            $display("error: tx_rr high outside a frame");
         end
         if (nb != 0)
         begin
            check_value("frame length", pkt_t'(nb), pkt_t'(etx_pkg::nbytes));
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("error: frame sent with no packet pending");
            end
            else
            begin
               check_value("tx_data", frame_buf, exp_q.pop_front());
               check_value("tx_rr", pkt_t'(rr_frame), pkt_t'(exp_rr_q.pop_front()));
               if (rr_frame)
                  rr_frames++;
            end
            nb = 0;
         end
      end
   end

   // ##########################################################
   // Test sequence
   // ##########################################################

   initial
   begin
      void'($urandom(32'ha8df_cfa6));
      clk = 1'b0;
      nreset = 1'b0;
      txwr_access = 1'b0;
      txrd_access = 1'b0;
      txrr_access = 1'b0;
      txwr_packet = '0;
      txrd_packet = '0;
      txrr_packet = '0;
      tx_wr_wait = 1'b0;
      tx_rd_wait = 1'b0;
      ctrlmode_bypass = 1'b0;
      ctrlmode = 4'h0;
      repeat (5)
         @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;

      check_value("tx_frame", pkt_t'(tx_frame), pkt_t'(0));
      check_value("tx_rr", pkt_t'(tx_rr), pkt_t'(0));
      check_value("txwr_wait", pkt_t'(txwr_wait), pkt_t'(0));
      check_value("txrd_wait", pkt_t'(txrd_wait), pkt_t'(0));
      check_value("txrr_wait", pkt_t'(txrr_wait), pkt_t'(0));
      report_test("1 reset state");

      offer_batch(1, 0, 0);
      drain();
      check_value("first byte latency", pkt_t'(first_cyc - accept_cyc), pkt_t'(2));
      report_test("2 single write");

      ctrlmode_bypass = 1'b1;
      ctrlmode = 4'($urandom);
      offer_batch(2, 2, 2);
      drain();
      ctrlmode_bypass = 1'b0;
      report_test("3 control-mode bypass");

      offer_batch(4, 4, 4);
      drain();
      report_test("4 priority order");

      check_value("response frames", pkt_t'(rr_frames), pkt_t'(rr_sent));
      report_test("5 response flag");

      offer_batch(2, 2, 2);
      while (!wr_fire)
         step();
      // First write now pending in the arbiter register
      tx_wr_wait = 1'b1;
      start_mark = frames_started;
      repeat (30)
         step();
      tx_wr_wait = 1'b0;
      tx_rd_wait = 1'b1;
      repeat (30)
         step();
      check_value("frames started", pkt_t'(frames_started), pkt_t'(start_mark));
      tx_rd_wait = 1'b0;
      drain();
      report_test("6 remote wait");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: project.f
src/etx_pkg.sv
src/etx_arbiter.sv
src/etx_link_fsm.sv
src/etx_byte_counter.sv
src/etx_shift_reg.sv
src/etx_top.sv
verification/etx_tb.sv

// File: run.sh
#!/bin/sh
# Build the eMesh transmit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module etx_tb \
   -f project.f \
   -o etx_sim

out="$(./obj_dir/etx_sim)"
echo "$out"
echo "$out" | grep -qx "TEST PASS"
